// File: hdl/sa_data_pkg.sv
////////////////////////////////////////////////////////////
// Data widths, element and accumulator types
// Beat structs for weights, inputs, results and skew
////////////////////////////////////////////////////////////
`default_nettype none

package sa_data_pkg;

  // Rows and columns of the array
  localparam int ARRAY_DIM = 4;

  typedef logic signed [7:0]  elem_t;
  typedef logic signed [31:0] acc_t;
  typedef logic [1:0]         row_idx_t;

  // Weight row or input vector, lane 0 in the low bits
  typedef struct packed {
    elem_t [ARRAY_DIM-1:0] lane;
  } vec_beat_t;

  // One sum per column, lane c from column c
  typedef struct packed {
    acc_t [ARRAY_DIM-1:0] lane;
  } result_beat_t;

  // Weight write broadcast to all columns
  typedef struct packed {
    logic      load;
    row_idx_t  row;
    vec_beat_t data;
  } wload_t;

  // Operands after the input skew, lane r already delayed r advances
  typedef struct packed {
    logic                  valid;
    elem_t [ARRAY_DIM-1:0] lane;
  } skew_t;

endpackage

`default_nettype wire

// File: hdl/sa_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Job state encoding and weight beat count type
////////////////////////////////////////////////////////////
`default_nettype none

package sa_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOAD   = 2'd1,
    STREAM = 2'd2,
    FINISH = 2'd3
  } job_state_t;

  typedef logic [2:0] wcount_t;

  // One weight beat per array row
  localparam wcount_t WEIGHT_BEATS = 3'd4;

endpackage

`default_nettype wire

// File: hdl/array_feeder.sv
////////////////////////////////////////////////////////////
// Weight and input stream acceptance
// Weight row numbering and triangular input skew
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module array_feeder (
  input  logic                   ap_clk,
  input  logic                   areset,
  input  logic                   load_phase,
  input  logic                   stream_open,
  input  logic                   advance,
  input  sa_data_pkg::vec_beat_t weight_in,
  input  logic                   weight_valid,
  output logic                   weight_ready,
  input  sa_data_pkg::vec_beat_t data_in,
  input  logic                   data_valid,
  output logic                   data_ready,
  output sa_data_pkg::wload_t    wload,
  output sa_data_pkg::skew_t     skew,
  output logic                   weight_taken,
  output logic                   data_taken
);
  import sa_data_pkg::*;

  row_idx_t              wrow;
  logic                  load_q;
  row_idx_t              row_q;
  vec_beat_t             data_q;
  logic                  skew_vld;
  elem_t [ARRAY_DIM-1:0] skew_lane;

  assign weight_ready = load_phase;
  assign data_ready   = stream_open & advance;
  assign weight_taken = weight_valid & weight_ready;
  assign data_taken   = data_valid & data_ready;

  ////////////////////////////////////////////////////////////
  // Weight path
  ////////////////////////////////////////////////////////////

  // Row index wraps back to 0 after the fourth beat
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wrow   <= '0;
      load_q <= 1'b0;
    end else begin
      load_q <= weight_taken;
      if (weight_taken) begin
        wrow <= wrow + 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (weight_taken) begin
      row_q  <= wrow;
      data_q <= weight_in;
    end
  end

  assign wload = '{load: load_q, row: row_q, data: data_q};

  ////////////////////////////////////////////////////////////
  // Input skew
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      skew_vld <= 1'b0;
    end else if (advance) begin
      skew_vld <= data_taken;
    end
  end

  // Lane r runs through r+1 registers
  for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_lane
    elem_t line [r+1];

    always_ff @(posedge ap_clk) begin
      if (advance) begin
        line[0] <= data_in.lane[r];
        for (int k = 1; k <= r; k++) begin
          line[k] <= line[k-1];
        end
      end
    end

    assign skew_lane[r] = line[r];
  end

  assign skew = '{valid: skew_vld, lane: skew_lane};

endmodule

`default_nettype wire

// File: hdl/mac_column.sv
////////////////////////////////////////////////////////////
// One array column with four stationary weights
// and a four-stage multiply-accumulate pipeline
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module mac_column #(
  parameter int COL_IDX = 0
) (
  input  logic                ap_clk,
  input  logic                areset,
  input  logic                advance,
  input  sa_data_pkg::wload_t wload,
  input  sa_data_pkg::skew_t  skew,
  output sa_data_pkg::acc_t   col_sum,
  output logic                col_valid
);
  import sa_data_pkg::*;

  elem_t                weight_mem [ARRAY_DIM];
  acc_t                 prod [ARRAY_DIM];
  acc_t                 psum [ARRAY_DIM];
  logic [ARRAY_DIM-1:0] vld;

  // Each column keeps its own lane of every weight row
  always_ff @(posedge ap_clk) begin
    if (wload.load) begin
      weight_mem[wload.row] <= wload.data.lane[COL_IDX];
    end
  end

  // Signed products, widened before the multiply
  for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_prod
    assign prod[r] = acc_t'(elem_t'(skew.lane[r])) * acc_t'(weight_mem[r]);
  end

  ////////////////////////////////////////////////////////////
  // Accumulate pipeline, stage r adds row r
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      vld <= '0;
    end else if (advance) begin
      vld <= {vld[ARRAY_DIM-2:0], skew.valid};
    end
  end

  always_ff @(posedge ap_clk) begin
    if (advance) begin
      psum[0] <= prod[0];
      for (int r = 1; r < ARRAY_DIM; r++) begin
        psum[r] <= psum[r-1] + prod[r];
      end
    end
  end

  assign col_sum   = psum[ARRAY_DIM-1];
  assign col_valid = vld[ARRAY_DIM-1];

endmodule

`default_nettype wire

// File: hdl/result_drain.sv
////////////////////////////////////////////////////////////
// Result holding register and pipeline advance
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module result_drain (
  input  logic                                  ap_clk,
  input  logic                                  areset,
  input  sa_data_pkg::acc_t                     col_sum [sa_data_pkg::ARRAY_DIM],
  input  logic [sa_data_pkg::ARRAY_DIM-1:0]     col_valid,
  input  logic                                  result_ready,
  output sa_data_pkg::result_beat_t             result,
  output logic                                  result_valid,
  output logic                                  advance,
  output logic                                  result_taken
);
  import sa_data_pkg::*;

  result_beat_t beat_d;

  always_comb begin
    for (int c = 0; c < ARRAY_DIM; c++) begin
      beat_d.lane[c] = col_sum[c];
    end
  end

  // Pipeline moves only when the register is free or leaving
  assign advance      = ~result_valid | result_ready;
  assign result_taken = result_valid & result_ready;

  // All columns share one valid pattern, column 0 stands for them
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      result_valid <= 1'b0;
    end else if (advance) begin
      result_valid <= col_valid[0];
    end
  end

  always_ff @(posedge ap_clk) begin
    if (advance && col_valid[0]) begin
      result <= beat_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/kernel_ctrl.sv
////////////////////////////////////////////////////////////
// Job FSM, beat counters, idle and done outputs
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module kernel_ctrl #(
  parameter int VEC_COUNT_W = 16
) (
  input  logic                   ap_clk,
  input  logic                   areset,
  input  logic                   ap_start,
  input  logic [VEC_COUNT_W-1:0] num_vectors,
  input  logic                   weight_taken,
  input  logic                   data_taken,
  input  logic                   result_taken,
  output logic                   load_phase,
  output logic                   stream_open,
  output logic                   ap_idle,
  output logic                   ap_done
);
  import sa_ctrl_pkg::*;

  job_state_t             state;
  wcount_t                wcnt;
  logic [VEC_COUNT_W-1:0] vec_total;
  logic [VEC_COUNT_W-1:0] issued;
  logic [VEC_COUNT_W-1:0] retired;

  // Vector count is captured once per job
  always_ff @(posedge ap_clk) begin
    if (state == IDLE && ap_start) begin
      vec_total <= num_vectors;
    end
  end

  ////////////////////////////////////////////////////////////
  // Job FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state   <= IDLE;
      wcnt    <= '0;
      issued  <= '0;
      retired <= '0;
      ap_idle <= 1'b1;
      ap_done <= 1'b0;
    end else begin
      ap_done <= 1'b0;
      if (data_taken) begin
        issued <= issued + 1'b1;
      end
      if (result_taken) begin
        retired <= retired + 1'b1;
      end
      case (state)
        IDLE: begin
          if (ap_start) begin
            state   <= LOAD;
            wcnt    <= '0;
            issued  <= '0;
            retired <= '0;
            ap_idle <= 1'b0;
          end
        end
        LOAD: begin
          if (weight_taken) begin
            wcnt <= wcnt + 1'b1;
            // Empty job skips the stream phase
            if (wcnt == WEIGHT_BEATS - 1) begin
              state <= (vec_total == '0) ? FINISH : STREAM;
            end
          end
        end
        STREAM: begin
          if (issued == vec_total) begin
            state <= FINISH;
          end
        end
        FINISH: begin
          if (retired == vec_total) begin
            state   <= IDLE;
            ap_done <= 1'b1;
            ap_idle <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign load_phase  = (state == LOAD);
  assign stream_open = (state == STREAM) && (issued < vec_total);

endmodule

`default_nettype wire

// File: hdl/sys_array_top.sv
////////////////////////////////////////////////////////////
// Matrix-vector engine top level
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module sys_array_top #(
  parameter int VEC_COUNT_W = 16
) (
  input  logic                      ap_clk,
  input  logic                      areset,
  input  logic                      ap_start,
  input  logic [VEC_COUNT_W-1:0]    num_vectors,
  output logic                      ap_idle,
  output logic                      ap_done,
  input  sa_data_pkg::vec_beat_t    weight_in,
  input  logic                      weight_valid,
  output logic                      weight_ready,
  input  sa_data_pkg::vec_beat_t    data_in,
  input  logic                      data_valid,
  output logic                      data_ready,
  output sa_data_pkg::result_beat_t result,
  output logic                      result_valid,
  input  logic                      result_ready
);
  import sa_data_pkg::*;

  logic                 load_phase;
  logic                 stream_open;
  logic                 advance;
  logic                 weight_taken;
  logic                 data_taken;
  logic                 result_taken;
  wload_t               wload;
  skew_t                skew;
  acc_t                 col_sum [ARRAY_DIM];
  logic [ARRAY_DIM-1:0] col_valid;

  kernel_ctrl #(
    .VEC_COUNT_W (VEC_COUNT_W)
  ) u_ctrl (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .ap_start     (ap_start),
    .num_vectors  (num_vectors),
    .weight_taken (weight_taken),
    .data_taken   (data_taken),
    .result_taken (result_taken),
    .load_phase   (load_phase),
    .stream_open  (stream_open),
    .ap_idle      (ap_idle),
    .ap_done      (ap_done)
  );

  array_feeder u_feeder (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .load_phase   (load_phase),
    .stream_open  (stream_open),
    .advance      (advance),
    .weight_in    (weight_in),
    .weight_valid (weight_valid),
    .weight_ready (weight_ready),
    .data_in      (data_in),
    .data_valid   (data_valid),
    .data_ready   (data_ready),
    .wload        (wload),
    .skew         (skew),
    .weight_taken (weight_taken),
    .data_taken   (data_taken)
  );

  // Columns share the broadcast weight load and skewed operands
  for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
    mac_column #(
      .COL_IDX (c)
    ) u_col (
      .ap_clk    (ap_clk),
      .areset    (areset),
      .advance   (advance),
      .wload     (wload),
      .skew      (skew),
      .col_sum   (col_sum[c]),
      .col_valid (col_valid[c])
    );
  end

  result_drain u_drain (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .col_sum      (col_sum),
    .col_valid    (col_valid),
    .result_ready (result_ready),
    .result       (result),
    .result_valid (result_valid),
    .advance      (advance),
    .result_taken (result_taken)
  );

endmodule

`default_nettype wire

// File: sim/sys_array_checker.sv
////////////////////////////////////////////////////////////
// Transfer monitor for the matrix-vector engine
// Expected result queue, in-order compare, error counts
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module sys_array_checker (
  input  logic                      ap_clk,
  input  logic                      areset,
  input  sa_data_pkg::vec_beat_t    weight_in,
  input  logic                      weight_valid,
  input  logic                      weight_ready,
  input  sa_data_pkg::vec_beat_t    data_in,
  input  logic                      data_valid,
  input  logic                      data_ready,
  input  sa_data_pkg::result_beat_t result,
  input  logic                      result_valid,
  input  logic                      result_ready,
  input  logic                      ap_done,
  output int                        data_errors,
  output int                        result_count,
  output int                        done_count,
  output int                        pending
);
  import sa_data_pkg::*;

  string        job_name = "none";
  vec_beat_t    w_row [ARRAY_DIM];
  int           w_idx;
  result_beat_t exp_q [$];
  result_beat_t exp_beat;

  // y[c] is the sum over r of x[r] * w[r][c]
  function automatic result_beat_t dot_product(vec_beat_t x);
    result_beat_t y;
    int           sum;
    for (int c = 0; c < ARRAY_DIM; c++) begin
      sum = 0;
      for (int r = 0; r < ARRAY_DIM; r++) begin
        sum = sum + int'($signed(x.lane[r])) * int'($signed(w_row[r].lane[c]));
      end
      y.lane[c] = sum;
    end
    return y;
  endfunction

  always @(posedge ap_clk) begin
    if (areset) begin
      w_idx   = 0;
      pending = 0;
      exp_q.delete();
    end else begin
      // Weight beats arrive as rows 0 to 3 of each job
      if (weight_valid && weight_ready) begin
        w_row[w_idx] = weight_in;
        w_idx = (w_idx + 1) % ARRAY_DIM;
      end
      if (data_valid && data_ready) begin
        exp_q.push_back(dot_product(data_in));
      end
      if (result_valid && result_ready) begin
        result_count++;
        if (exp_q.size() == 0) begin
          data_errors++;
          $display("%s: result beat %h arrived with no input beat pending", job_name, result);
        end else begin
          exp_beat = exp_q.pop_front();
          if (result !== exp_beat) begin
            data_errors++;
            $display("FAILED %s: result expected %h actual %h", job_name, exp_beat, result);
          end
        end
      end
      if (ap_done) begin
        done_count++;
      end
      pending = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// File: sim/sys_array_props.sv
////////////////////////////////////////////////////////////
// Handshake and control assertions, bound to the top level
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module sys_array_props (
  input logic                      ap_clk,
  input logic                      areset,
  input sa_data_pkg::result_beat_t result,
  input logic                      result_valid,
  input logic                      result_ready,
  input logic                      ap_done,
  input logic                      weight_ready,
  input logic                      data_ready
);

  int fail_count = 0;

  // A held result keeps valid and payload until taken
  result_held: assert property (@(posedge ap_clk) disable iff (areset)
    result_valid && !result_ready |=> result_valid && $stable(result))
    else begin
      $error("result payload changed while held under back-pressure");
      fail_count++;
    end

  done_pulse: assert property (@(posedge ap_clk) disable iff (areset)
    ap_done |=> !ap_done)
    else begin
      $error("ap_done stayed high for more than one cycle");
      fail_count++;
    end

  // Weight load and input streaming never overlap
  ready_excl: assert property (@(posedge ap_clk) disable iff (areset)
    !(weight_ready && data_ready))
    else begin
      $error("weight_ready and data_ready high together");
      fail_count++;
    end

endmodule

bind sys_array_top sys_array_props props (
  .ap_clk       (ap_clk),
  .areset       (areset),
  .result       (result),
  .result_valid (result_valid),
  .result_ready (result_ready),
  .ap_done      (ap_done),
  .weight_ready (weight_ready),
  .data_ready   (data_ready)
);

`default_nettype wire

// File: sim/tb_sys_array.sv
////////////////////////////////////////////////////////////
// Testbench for the matrix-vector engine
// Clock, reset, job table, stimulus loop, timeout, verdict
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module tb_sys_array;
  import sa_data_pkg::*;

  localparam int VEC_COUNT_W = 16;
  localparam int NUM_JOBS    = 6;

  // Weight rows with row 0 in the low 32 bits, lane 0 lowest
  typedef struct packed {
    logic [127:0]           wrows;
    logic [VEC_COUNT_W-1:0] nvec;
    logic                   rand_w;
    logic                   rand_in;
    logic                   rand_ready;
    logic                   busy_start;
  } job_t;

  localparam job_t JOBS [NUM_JOBS] = '{
    '{128'h01000000_00010000_00000100_00000001, 16'd8,  1'b0, 1'b0, 1'b0, 1'b0},
    '{128'h7f7f7f7f_7f7f7f7f_80808080_80808080, 16'd6,  1'b0, 1'b0, 1'b0, 1'b0},
    '{128'h0,                                   16'd20, 1'b1, 1'b1, 1'b0, 1'b0},
    '{128'h0,                                   16'd24, 1'b1, 1'b1, 1'b1, 1'b1},
    '{128'h0,                                   16'd0,  1'b1, 1'b0, 1'b0, 1'b0},
    '{128'h02fe03fd_fc04fb05_0a0bf60c_81817f7f, 16'd12, 1'b0, 1'b0, 1'b1, 1'b0}
  };

  function automatic string job_label(int j);
    case (j)
      0:       return "identity";
      1:       return "extremes";
      2:       return "random";
      3:       return "backpressure";
      4:       return "empty";
      default: return "reload";
    endcase
  endfunction

  // Weights, vectors and drain per job, with room for back-pressure
  function automatic int timeout_limit();
    int sum;
    sum = 0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      sum = sum + 4 + 2 * int'(JOBS[j].nvec) + 20;
    end
    return sum * 4;
  endfunction

  localparam int TIMEOUT = timeout_limit();

  // Fixed inputs cycle through -128, 127 and a ramp
  function automatic elem_t fixed_elem(int v, int r);
    case ((v + r) % 3)
      0:       return elem_t'(8'h80);
      1:       return elem_t'(8'h7f);
      default: return elem_t'(v * 13 + r * 5 - 40);
    endcase
  endfunction

  logic                   ap_clk;
  logic                   areset;
  logic                   ap_start;
  logic [VEC_COUNT_W-1:0] num_vectors;
  logic                   ap_idle;
  logic                   ap_done;
  vec_beat_t              weight_in;
  logic                   weight_valid;
  logic                   weight_ready;
  vec_beat_t              data_in;
  logic                   data_valid;
  logic                   data_ready;
  result_beat_t           result;
  logic                   result_valid;
  logic                   result_ready = 1'b0;
  logic                   bp_random = 1'b0;
  int                     data_errors;
  int                     result_count;
  int                     done_count;
  int                     pending;
  int                     ctrl_errors = 0;
  int                     cycles = 0;

  sys_array_top #(
    .VEC_COUNT_W (VEC_COUNT_W)
  ) uut (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .ap_start     (ap_start),
    .num_vectors  (num_vectors),
    .ap_idle      (ap_idle),
    .ap_done      (ap_done),
    .weight_in    (weight_in),
    .weight_valid (weight_valid),
    .weight_ready (weight_ready),
    .data_in      (data_in),
    .data_valid   (data_valid),
    .data_ready   (data_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready)
  );

  sys_array_checker chk (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .weight_in    (weight_in),
    .weight_valid (weight_valid),
    .weight_ready (weight_ready),
    .data_in      (data_in),
    .data_valid   (data_valid),
    .data_ready   (data_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .ap_done      (ap_done),
    .data_errors  (data_errors),
    .result_count (result_count),
    .done_count   (done_count),
    .pending      (pending)
  );

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  always @(negedge ap_clk) begin
    result_ready <= bp_random ? 1'($urandom) : 1'b1;
  end

  always @(posedge ap_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_count(string job, string what, int expected, int actual);
    if (expected != actual) begin
      ctrl_errors++;
      $display("FAILED %s: %s expected %0d actual %0d", job, what, expected, actual);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_weight(input vec_beat_t beat);
    weight_in    = beat;
    weight_valid = 1'b1;
    #1;
    while (weight_ready !== 1'b1) begin
      @(negedge ap_clk);
      #1;
    end
    @(negedge ap_clk);
  endtask

  task automatic send_data(input vec_beat_t beat);
    data_in    = beat;
    data_valid = 1'b1;
    #1;
    while (data_ready !== 1'b1) begin
      @(negedge ap_clk);
      #1;
    end
    @(negedge ap_clk);
  endtask

  initial begin
    vec_beat_t beat;
    int        done_before;
    int        results_before;
    int        total;
    void'($urandom(32'h2afd5bb0));
    areset       = 1'b1;
    ap_start     = 1'b0;
    num_vectors  = '0;
    weight_in    = '0;
    weight_valid = 1'b0;
    data_in      = '0;
    data_valid   = 1'b0;
    // Four rising edges in reset, release on the falling edge after
    repeat (4) @(posedge ap_clk);
    @(negedge ap_clk);
    areset = 1'b0;
    check_count("reset", "ap_idle", 1, int'(ap_idle));
    check_count("reset", "result_valid", 0, int'(result_valid));

    for (int j = 0; j < NUM_JOBS; j++) begin
      chk.job_name   = job_label(j);
      bp_random      <= JOBS[j].rand_ready;
      done_before    = done_count;
      results_before = result_count;
      ap_start       = 1'b1;
      num_vectors    = JOBS[j].nvec;
      @(negedge ap_clk);
      ap_start = 1'b0;
      check_count(job_label(j), "ap_idle after start", 0, int'(ap_idle));

      for (int r = 0; r < ARRAY_DIM; r++) begin
        if (JOBS[j].rand_w) begin
          beat = vec_beat_t'($urandom);
        end else begin
          beat = vec_beat_t'(JOBS[j].wrows[r*32 +: 32]);
        end
        send_weight(beat);
      end
      weight_valid = 1'b0;

      for (int v = 0; v < int'(JOBS[j].nvec); v++) begin
        for (int r = 0; r < ARRAY_DIM; r++) begin
          beat.lane[r] = JOBS[j].rand_in ? elem_t'($urandom) : fixed_elem(v, r);
        end
        // Stray start while the job streams
        ap_start = JOBS[j].busy_start && (v == 2);
        send_data(beat);
      end
      data_valid = 1'b0;
      ap_start   = 1'b0;

      while (ap_done !== 1'b1) begin
        @(negedge ap_clk);
      end
      // Window for a stray second done pulse
      repeat (8) @(negedge ap_clk);
      check_count(job_label(j), "done pulses", 1, done_count - done_before);
      check_count(job_label(j), "results", int'(JOBS[j].nvec), result_count - results_before);
      check_count(job_label(j), "results still pending", 0, pending);
      check_count(job_label(j), "ap_idle after done", 1, int'(ap_idle));
    end

    total = data_errors + ctrl_errors + uut.props.fail_count;
    $display("Error counts: data %0d, control %0d, assertion %0d",
             data_errors, ctrl_errors, uut.props.fail_count);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hdl/sa_data_pkg.sv
hdl/sa_ctrl_pkg.sv
hdl/array_feeder.sv
hdl/mac_column.sv
hdl/result_drain.sv
hdl/kernel_ctrl.sv
hdl/sys_array_top.sv
sim/sys_array_checker.sv
sim/sys_array_props.sv
sim/tb_sys_array.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sys_array
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS     := $(shell grep -v '^+' vlog.f)
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := *** PASSED ***

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) vlog.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
